// ==== alut_cases.txt ====
# columns: name operation address(hex) data-or-expected(hex)
# operations: wr, rd compare, cap read only, gt above last read, poll until idle, wait cycles
rst_bb_age rd 24 ffffffff
rst_mac_l rd 18 00000000
rst_d_port rd 14 00000000
rst_status rd 2c 00000000
rst_lst_port rd 3c 00000000
mac_l wr 18 12345678
mac_l_back rd 18 12345678
mac_u wr 1c ffffbeef
mac_u_back rd 1c 0000beef
s_port_all wr 10 ffffffff
s_port_back rd 10 00000003
div_clk wr 28 fffff0aa
div_clk_back rd 28 000000aa
div_clk_zero wr 28 00000000
time_first cap 20 00000000
time_gap wait 00 000000c8
time_later gt 20 00000000
s_addr_u wr 0c 000000aa
d_addr_u wr 04 000000aa
learn_a_s wr 08 00000001
learn_a_port wr 10 00000002
miss_d wr 00 00000009
learn_a_cmd wr 30 00000001
learn_a_poll poll 2c 00000000
miss_mask rd 14 0000001b
learn_b_s wr 08 00000002
learn_b_port wr 10 00000001
hit_a_d wr 00 00000001
hit_a_cmd wr 30 00000001
hit_a_poll poll 2c 00000000
hit_a_mask rd 14 00000004
own_d_l wr 00 12345678
own_d_u wr 04 0000beef
own_cmd wr 30 00000001
own_poll poll 2c 00000000
own_mask rd 14 00000000
own_restore wr 04 000000aa
learn_c_s wr 08 00000003
learn_c_port wr 10 00000003
learn_c_cmd wr 30 00000001
learn_c_poll poll 2c 00000000
learn_d_s wr 08 00000004
learn_d_port wr 10 00000000
learn_d_cmd wr 30 00000001
learn_d_poll poll 2c 00000000
learn_e_s wr 08 00000005
learn_e_port wr 10 00000002
learn_e_cmd wr 30 00000001
learn_e_settle wait 00 0000000a
ovf_lst_l rd 34 00000001
ovf_lst_u rd 38 000000aa
ovf_lst_port rd 3c 00000002
ovf_status_set rd 2c 00000004
ovf_status_clr rd 2c 00000000
keep_age_cmd wr 30 00000002
keep_age_poll poll 2c 00000000
keep_d wr 00 00000002
keep_chk_cmd wr 30 00000001
keep_chk_poll poll 2c 00000000
keep_mask rd 14 00000002
keep_lst_port rd 3c 00000002
age_zero wr 24 00000000
age_cmd wr 30 00000002
age_poll poll 2c 00000000
age_lst_l rd 34 00000004
age_lst_u rd 38 000000aa
age_lst_port rd 3c 00000000
aged_b_cmd wr 30 00000001
aged_b_poll poll 2c 00000000
aged_b_mask rd 14 0000001b
aged_d wr 00 00000004
aged_d_cmd wr 30 00000001
aged_d_poll poll 2c 00000000
aged_d_mask rd 14 0000001b

// ==== build.f ====
alut_pkg.sv
alut_reg_bank.sv
alut_timer.sv
alut_addr_checker.sv
alut_age_checker.sv
alut_top.sv
alut_assertions.sv
alut_checker.sv
tb_alut.sv

// ==== Bender.yml ====
package:
  name: alut

sources:
  - alut_pkg.sv
  - alut_reg_bank.sv
  - alut_timer.sv
  - alut_addr_checker.sv
  - alut_age_checker.sv
  - alut_top.sv
  - target: simulation
    files:
      - alut_assertions.sv
      - alut_checker.sv
      - tb_alut.sv

// ==== tb_alut.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_alut;
   import alut_pkg::*;

   localparam int n_entries = 4;

   logic        pclk4;
   logic        n_p_reset4;
   logic        psel;
   logic        penable;
   logic        pwrite;
   logic [6:0]  paddr;
   logic [31:0] pwdata;
   logic [31:0] prdata;

   int          limit_cycles = 0;   // watchdog length, set once cases are counted
   int          n_other      = 0;   // case file problems

   alut_top #(.n_entries(n_entries)) i_dut
   (
      .pclk4      (pclk4),
      .n_p_reset4 (n_p_reset4),
      .psel       (psel),
      .penable    (penable),
      .pwrite     (pwrite),
      .paddr      (paddr),
      .pwdata     (pwdata),
      .prdata     (prdata)
   );

   alut_checker i_checker
   (
      .pclk4      (pclk4),
      .n_p_reset4 (n_p_reset4),
      .psel       (psel),
      .penable    (penable),
      .pwrite     (pwrite),
      .paddr      (paddr),
      .prdata     (prdata)
   );

   bind alut_reg_bank alut_assertions i_assertions
   (
      .pclk4            (pclk4),
      .n_p_reset4       (n_p_reset4),
      .read_en          (read_en),
      .write_en         (write_en),
      .command          (command),
      .add_check_active (add_check_active),
      .age_check_active (age_check_active)
   );

   initial
   begin
      pclk4 = 1'b0;
      forever #5 pclk4 = ~pclk4;
   end

   // ------------------------------------------------------------------------
   // apb transfers, inputs move 1 ns after the edge
   // ------------------------------------------------------------------------
   task automatic apb_write(input logic [6:0] addr, input logic [31:0] data);
      @(posedge pclk4);
      #1;
      psel    = 1'b1;             // setup
      penable = 1'b0;
      pwrite  = 1'b1;
      paddr   = addr;
      pwdata  = data;
      @(posedge pclk4);
      #1;
      penable = 1'b1;             // access, register updates at next edge
      @(posedge pclk4);
      #1;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic apb_read(input logic [6:0] addr, output logic [31:0] data);
      @(posedge pclk4);
      #1;
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = addr;
      @(posedge pclk4);
      #1;
      penable = 1'b1;
      data    = prdata;           // registered, stable all access phase
      @(posedge pclk4);
      #1;
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   // status bit 0 is the busy flag of both checkers
   task automatic wait_idle();
      logic [31:0] status;
      status = 32'h1;
      while (status[0])
         apb_read(al_status, status);
   endtask

   initial
   begin
      int          fd;
      int          rc;
      int          n_lines;
      int          n_errors;
      bit          done;
      string       line;
      string       name;
      string       op;
      logic [31:0] addr;
      logic [31:0] data;
      logic [31:0] rd_data;

      psel       = 1'b0;
      penable    = 1'b0;
      pwrite     = 1'b0;
      paddr      = '0;
      pwdata     = '0;
      n_p_reset4 = 1'b0;
      n_lines    = 0;
      done       = 1'b0;

      // first pass only sizes the watchdog
      fd = $fopen("alut_cases.txt", "r");
      if (fd == 0)
      begin
         $display("case file alut_cases.txt could not be opened");
         n_other++;
      end
      else
      begin
         while (!$feof(fd))
         begin
            rc = $fgets(line, fd);
            if (rc > 0)
               n_lines++;
         end
         $fclose(fd);
         fd = $fopen("alut_cases.txt", "r");
      end
      limit_cycles = n_lines * 200 + 1000;

      repeat (5) @(posedge pclk4);
      #1;
      n_p_reset4 = 1'b1;

      while (!done && fd != 0)
      begin
         rc = $fscanf(fd, "%s", name);
         if (rc != 1)
            done = 1'b1;                          // end of file
         else if (name[0] == "#")
            rc = $fgets(line, fd);                // column legend
         else
         begin
            rc = $fscanf(fd, "%s %h %h", op, addr, data);
            if (rc != 3)
            begin
               $display("case %s is missing its operation, address or data", name);
               n_other++;
               done = 1'b1;
            end
            else
               case (op)
                  "wr"   : apb_write(addr[6:0], data);
                  "rd"   :
                  begin
                     i_checker.expect_read(name, data, 1);
                     apb_read(addr[6:0], rd_data);
                  end
                  "cap"  : apb_read(addr[6:0], rd_data);   // reference for gt
                  "gt"   :
                  begin
                     i_checker.expect_read(name, data, 2);
                     apb_read(addr[6:0], rd_data);
                  end
                  "poll" : wait_idle();
                  "wait" : repeat (data) @(posedge pclk4);
                  default :
                  begin
                     $display("case %s has an unknown operation %s", name, op);
                     n_other++;
                  end
               endcase
         end
      end
      if (fd != 0)
         $fclose(fd);

      repeat (2) @(posedge pclk4);
      n_errors = i_checker.n_errors + i_dut.i_reg_bank.i_assertions.fail_count + n_other;
      $display("checks %0d, value errors %0d, assertion errors %0d, other errors %0d",
               i_checker.n_checks, i_checker.n_errors,
               i_dut.i_reg_bank.i_assertions.fail_count, n_other);
      if (n_errors == 0)
         $display("*** TEST PASSED ***");
      else
         $display("*** TEST FAILED ***");
      $finish;
   end

   // watchdog, sized from the case count
   initial
   begin
      wait (limit_cycles > 0);
      repeat (limit_cycles) @(posedge pclk4);
      $display("timeout, cases not finished after %0d cycles", limit_cycles);
      $display("*** TEST FAILED ***");
      $finish;
   end

endmodule

`default_nettype wire

// ==== alut_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module alut_checker
(
   input  logic        pclk4,
   input  logic        n_p_reset4,
   input  logic        psel,
   input  logic        penable,
   input  logic        pwrite,
   input  logic [6:0]  paddr,
   input  logic [31:0] prdata
);
   import alut_pkg::*;

   string       exp_name;          // case the next read belongs to
   logic [31:0] exp_data;
   int          exp_mode = 0;      // 0 no compare, 1 equal, 2 above last read
   logic [31:0] last_data = '0;    // previous read, any mode
   int          n_checks = 0;
   int          n_errors = 0;
   al_reg_e     reg_name;

   // armed by the testbench just before a read
   task automatic expect_read(input string name, input logic [31:0] data, input int mode);
      exp_name = name;
      exp_data = data;
      exp_mode = mode;
   endtask

   // ------------------------------------------------------------------------
   // sample mid access phase, data settled since the setup edge
   // ------------------------------------------------------------------------
   always @(negedge pclk4)
   begin
      if (n_p_reset4 && psel && penable && !pwrite)
      begin
         reg_name = al_reg_e'(paddr);
         if (exp_mode == 1)
         begin
            n_checks++;
            if (prdata !== exp_data)
            begin
               n_errors++;
               $display("[ERROR] %s (%s): expected %h, actual %h",
                        exp_name, reg_name.name(), exp_data, prdata);
            end
         end
         else if (exp_mode == 2)
         begin
            n_checks++;
            if (!(prdata > last_data))   // free running count must move on
            begin
               n_errors++;
               $display("[ERROR] %s (%s): expected above %h, actual %h",
                        exp_name, reg_name.name(), last_data, prdata);
            end
         end
         last_data = prdata;
         exp_mode  = 0;                  // one compare per arm
      end
   end

endmodule

`default_nettype wire

// ==== alut_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module alut_assertions
(
   input  logic              pclk4,
   input  logic              n_p_reset4,
   input  logic              read_en,
   input  logic              write_en,
   input  alut_pkg::al_cmd_e command,
   input  logic              add_check_active,
   input  logic              age_check_active
);
   import alut_pkg::*;

   int fail_count = 0;   // failed assertions so far

   // a transfer set up as a read never completes as a write
   rw_exclusive : assert property (@(posedge pclk4) disable iff (!n_p_reset4)
      read_en |=> !write_en)
      else
      begin
         fail_count++;
         $error("read setup followed by a write access in the same transfer");
      end

   cmd_one_shot : assert property (@(posedge pclk4) disable iff (!n_p_reset4)
      (command != cmd_none) |=> (command == cmd_none))
      else
      begin
         fail_count++;
         $error("command held longer than one cycle");
      end

   // software never overlaps lookup and aging
   active_exclusive : assert property (@(posedge pclk4) disable iff (!n_p_reset4)
      !(add_check_active && age_check_active))
      else
      begin
         fail_count++;
         $error("address and age checkers active together");
      end

endmodule

`default_nettype wire

// ==== alut_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module alut_top
#(
   parameter int n_entries = 4
)
(
   input  logic        pclk4,
   input  logic        n_p_reset4,
   input  logic        psel,
   input  logic        penable,
   input  logic        pwrite,
   input  logic [6:0]  paddr,
   input  logic [31:0] pwdata,
   output logic [31:0] prdata
);
   import alut_pkg::*;

   // register bank outputs
   logic [mac_w-1:0]             mac_addr;
   logic [mac_w-1:0]             d_addr;
   logic [mac_w-1:0]             s_addr;
   logic [port_w-1:0]            s_port;
   logic [time_w-1:0]            best_bfr_age;
   logic [7:0]                   div_clk;
   al_cmd_e                      command;
   logic                         clear_reused;
   logic [time_w-1:0]            curr_time;

   // checker results
   logic                         add_check_active;
   logic                         age_check_active;
   logic                         inval_in_prog;
   logic                         reused;
   logic [dmask_w-1:0]           d_port;
   logic [mac_w-1:0]             lst_inv_addr_nrm;
   logic [port_w-1:0]            lst_inv_port_nrm;
   logic [mac_w-1:0]             lst_inv_addr_cmd;
   logic [port_w-1:0]            lst_inv_port_cmd;

   // table read port between the checkers
   logic [$clog2(n_entries)-1:0] tbl_idx;
   logic                         tbl_inval;
   logic                         tbl_valid;
   logic [mac_w-1:0]             tbl_addr;
   logic [port_w-1:0]            tbl_port;
   logic [time_w-1:0]            tbl_stamp;

   alut_reg_bank i_reg_bank (.*);

   alut_timer i_timer (.*);

   alut_addr_checker #(.n_entries(n_entries)) i_addr_checker (.*);

   alut_age_checker #(.n_entries(n_entries)) i_age_checker (.*);

endmodule

`default_nettype wire

// ==== alut_age_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module alut_age_checker
#(
   parameter int n_entries = 4
)
(
   input  logic                            pclk4,
   input  logic                            n_p_reset4,
   input  alut_pkg::al_cmd_e               command,
   input  logic [alut_pkg::time_w-1:0]     curr_time,
   input  logic [alut_pkg::time_w-1:0]     best_bfr_age,
   input  logic                            tbl_valid,
   input  logic [alut_pkg::mac_w-1:0]      tbl_addr,
   input  logic [alut_pkg::port_w-1:0]     tbl_port,
   input  logic [alut_pkg::time_w-1:0]     tbl_stamp,
   output logic [$clog2(n_entries)-1:0]    tbl_idx,
   output logic                            tbl_inval,
   output logic                            age_check_active,
   output logic                            inval_in_prog,
   output logic [alut_pkg::mac_w-1:0]      lst_inv_addr_cmd,
   output logic [alut_pkg::port_w-1:0]     lst_inv_port_cmd
);
   import alut_pkg::*;

   localparam int idx_w = $clog2(n_entries);

   age_state_e        state;
   logic [time_w-1:0] entry_age;    // modulo time since last learn

   assign entry_age = curr_time - tbl_stamp;

   // drop the entry under the scan pointer if it is stale
   assign tbl_inval = (state == age_scan) & tbl_valid & (entry_age > best_bfr_age);

   assign inval_in_prog    = tbl_inval;    // one cycle per dropped entry
   assign lst_inv_addr_cmd = tbl_addr;
   assign lst_inv_port_cmd = tbl_port;
   assign age_check_active = (state == age_scan);

   // one entry per cycle, ascending
   always_ff @(posedge pclk4 or negedge n_p_reset4)
   begin
      if (!n_p_reset4)
      begin
         state   <= age_idle;
         tbl_idx <= '0;
      end
      else
      begin
         case (state)
            age_idle :
               if (command == cmd_age)
               begin
                  state   <= age_scan;
                  tbl_idx <= '0;
               end
            default :
               if (tbl_idx == idx_w'(n_entries - 1))
                  state <= age_idle;              // last entry done
               else
                  tbl_idx <= tbl_idx + 1'b1;
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== alut_addr_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module alut_addr_checker
#(
   parameter int n_entries = 4
)
(
   input  logic                            pclk4,
   input  logic                            n_p_reset4,
   input  alut_pkg::al_cmd_e               command,
   input  logic [alut_pkg::mac_w-1:0]      mac_addr,
   input  logic [alut_pkg::mac_w-1:0]      d_addr,
   input  logic [alut_pkg::mac_w-1:0]      s_addr,
   input  logic [alut_pkg::port_w-1:0]     s_port,
   input  logic [alut_pkg::time_w-1:0]     curr_time,
   input  logic                            clear_reused,
   input  logic [$clog2(n_entries)-1:0]    tbl_idx,
   input  logic                            tbl_inval,
   output logic [alut_pkg::dmask_w-1:0]    d_port,
   output logic                            add_check_active,
   output logic                            reused,
   output logic [alut_pkg::mac_w-1:0]      lst_inv_addr_nrm,
   output logic [alut_pkg::port_w-1:0]     lst_inv_port_nrm,
   output logic                            tbl_valid,
   output logic [alut_pkg::mac_w-1:0]      tbl_addr,
   output logic [alut_pkg::port_w-1:0]     tbl_port,
   output logic [alut_pkg::time_w-1:0]     tbl_stamp
);
   import alut_pkg::*;

   localparam int idx_w = $clog2(n_entries);

   chk_state_e           state;
   logic [n_entries-1:0] ent_valid;
   logic [mac_w-1:0]     ent_addr  [n_entries];
   logic [port_w-1:0]    ent_port  [n_entries];
   logic [time_w-1:0]    ent_stamp [n_entries];
   logic [idx_w-1:0]     rr_ptr;          // next victim when full

   logic                 d_hit;
   logic [port_w-1:0]    d_hit_port;
   logic                 s_hit;
   logic [idx_w-1:0]     s_hit_idx;
   logic                 free_found;
   logic [idx_w-1:0]     free_idx;
   logic [idx_w-1:0]     wr_idx;          // entry touched in learn
   logic                 victim;          // learn must overwrite
   logic [dmask_w-1:0]   miss_mask;

   // ------------------------------------------------------------------------
   // single cycle associative search
   // ------------------------------------------------------------------------
   always_comb
   begin
      d_hit      = 1'b0;
      d_hit_port = '0;
      s_hit      = 1'b0;
      s_hit_idx  = '0;
      free_found = 1'b0;
      free_idx   = '0;
      for (int i = n_entries - 1; i >= 0; i--)   // downward, lowest wins
      begin
         if (ent_valid[i] && (ent_addr[i] == d_addr))
         begin
            d_hit      = 1'b1;
            d_hit_port = ent_port[i];
         end
         if (ent_valid[i] && (ent_addr[i] == s_addr))
         begin
            s_hit     = 1'b1;
            s_hit_idx = idx_w'(i);
         end
         if (!ent_valid[i])
         begin
            free_found = 1'b1;
            free_idx   = idx_w'(i);
         end
      end
   end

   assign victim    = ~s_hit & ~free_found;
   assign wr_idx    = s_hit ? s_hit_idx : (free_found ? free_idx : rr_ptr);
   assign miss_mask = ~(dmask_w'(1) << s_port);   // broadcast bit stays set

   assign add_check_active = (state != chk_idle);

   // table read port for the age scan
   assign tbl_valid = ent_valid[tbl_idx];
   assign tbl_addr  = ent_addr[tbl_idx];
   assign tbl_port  = ent_port[tbl_idx];
   assign tbl_stamp = ent_stamp[tbl_idx];

   // idle -> lookup -> learn -> idle
   always_ff @(posedge pclk4 or negedge n_p_reset4)
   begin
      if (!n_p_reset4)
      begin
         state  <= chk_idle;
         d_port <= '0;
      end
      else
      begin
         case (state)
            chk_idle :
               if (command == cmd_check)
                  state <= chk_lookup;
            chk_lookup :
            begin
               state <= chk_learn;
               if (d_addr == mac_addr)
                  d_port <= '0;                          // for the switch itself
               else if (d_hit)
                  d_port <= dmask_w'(1) << d_hit_port;   // known port
               else
                  d_port <= miss_mask;                   // flood
            end
            default :
               state <= chk_idle;
         endcase
      end
   end

   // valid bits, victim pointer and sticky reused flag
   always_ff @(posedge pclk4 or negedge n_p_reset4)
   begin
      if (!n_p_reset4)
      begin
         ent_valid <= '0;
         rr_ptr    <= '0;
         reused    <= 1'b0;
      end
      else
      begin
         if (clear_reused)
            reused <= 1'b0;
         if (tbl_inval)
            ent_valid[tbl_idx] <= 1'b0;
         if (state == chk_learn)
         begin
            ent_valid[wr_idx] <= 1'b1;
            if (victim)
            begin
               reused <= 1'b1;
               rr_ptr <= (rr_ptr == idx_w'(n_entries - 1)) ? '0 : rr_ptr + 1'b1;
            end
         end
      end
   end

   // entry payload
   always_ff @(posedge pclk4)
   begin
      if (state == chk_learn)
      begin
         ent_addr[wr_idx]  <= s_addr;       // unchanged on refresh
         ent_port[wr_idx]  <= s_port;
         ent_stamp[wr_idx] <= curr_time;
         if (victim)
         begin
            lst_inv_addr_nrm <= ent_addr[rr_ptr];
            lst_inv_port_nrm <= ent_port[rr_ptr];
         end
      end
   end

endmodule

`default_nettype wire

// ==== alut_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module alut_timer
(
   input  logic                          pclk4,
   input  logic                          n_p_reset4,
   input  logic [7:0]                    div_clk,
   output logic [alut_pkg::time_w-1:0]   curr_time
);

   logic [7:0] presc;   // cycles left in this tick

   // one tick every div_clk+1 cycles
   always_ff @(posedge pclk4 or negedge n_p_reset4)
   begin
      if (!n_p_reset4)
      begin
         presc     <= '0;
         curr_time <= '0;
      end
      else if (presc == 8'd0)
      begin
         presc     <= div_clk;              // reload picks up new divider
         curr_time <= curr_time + 1'b1;     // free running, wraps
      end
      else
         presc <= presc - 8'd1;
   end

endmodule

`default_nettype wire

// ==== alut_reg_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

module alut_reg_bank
(
   input  logic                           pclk4,
   input  logic                           n_p_reset4,
   input  logic                           psel,
   input  logic                           penable,
   input  logic                           pwrite,
   input  logic [6:0]                     paddr,
   input  logic [31:0]                    pwdata,
   input  logic [alut_pkg::time_w-1:0]    curr_time,
   input  logic                           add_check_active,
   input  logic                           age_check_active,
   input  logic                           inval_in_prog,
   input  logic                           reused,
   input  logic [alut_pkg::dmask_w-1:0]   d_port,
   input  logic [alut_pkg::mac_w-1:0]     lst_inv_addr_nrm,
   input  logic [alut_pkg::port_w-1:0]    lst_inv_port_nrm,
   input  logic [alut_pkg::mac_w-1:0]     lst_inv_addr_cmd,
   input  logic [alut_pkg::port_w-1:0]    lst_inv_port_cmd,
   output logic [alut_pkg::mac_w-1:0]     mac_addr,
   output logic [alut_pkg::mac_w-1:0]     d_addr,
   output logic [alut_pkg::mac_w-1:0]     s_addr,
   output logic [alut_pkg::port_w-1:0]    s_port,
   output logic [alut_pkg::time_w-1:0]    best_bfr_age,
   output logic [7:0]                     div_clk,
   output alut_pkg::al_cmd_e              command,
   output logic [31:0]                    prdata,
   output logic                           clear_reused
);
   import alut_pkg::*;

   logic                read_en;        // apb setup phase of a read
   logic                write_en;       // apb access phase of a write
   logic                active;         // either checker busy

   logic [31:0]         frm_d_addr_l;
   logic [15:0]         frm_d_addr_u;
   logic [31:0]         frm_s_addr_l;
   logic [15:0]         frm_s_addr_u;
   logic [31:0]         mac_addr_l;
   logic [15:0]         mac_addr_u;
   logic [31:0]         lst_inv_addr_l;
   logic [15:0]         lst_inv_addr_u;
   logic [port_w-1:0]   lst_inv_port;

   assign read_en  = psel & ~penable & ~pwrite;
   assign write_en = psel & penable & pwrite;
   assign active   = add_check_active | age_check_active;

   assign mac_addr = {mac_addr_u, mac_addr_l};
   assign d_addr   = {frm_d_addr_u, frm_d_addr_l};
   assign s_addr   = {frm_s_addr_u, frm_s_addr_l};

   // status read acknowledges the overwrite flag, but not mid-check
   assign clear_reused = read_en & (paddr == al_status) & ~active;

   // ------------------------------------------------------------------------
   // read mux, registered so data sits in the access phase
   // ------------------------------------------------------------------------
   always_ff @(posedge pclk4 or negedge n_p_reset4)
   begin
      if (!n_p_reset4)
         prdata <= '0;
      else if (read_en)
      begin
         case (paddr)
            al_frm_d_addr_l   : prdata <= frm_d_addr_l;
            al_frm_d_addr_u   : prdata <= 32'(frm_d_addr_u);
            al_frm_s_addr_l   : prdata <= frm_s_addr_l;
            al_frm_s_addr_u   : prdata <= 32'(frm_s_addr_u);
            al_s_port         : prdata <= 32'(s_port);
            al_d_port         : prdata <= 32'(d_port);
            al_mac_addr_l     : prdata <= mac_addr_l;
            al_mac_addr_u     : prdata <= 32'(mac_addr_u);
            al_cur_time       : prdata <= curr_time;
            al_bb_age         : prdata <= best_bfr_age;
            al_div_clk        : prdata <= 32'(div_clk);
            al_status         : prdata <= {29'd0, reused, inval_in_prog, active};
            al_lst_inv_addr_l : prdata <= lst_inv_addr_l;
            al_lst_inv_addr_u : prdata <= 32'(lst_inv_addr_u);
            al_lst_inv_port   : prdata <= 32'(lst_inv_port);
            default           : prdata <= '0;   // hole in the map
         endcase
      end
      else
         prdata <= '0;                           // bus quiet outside reads
   end

   // ------------------------------------------------------------------------
   // software writable registers
   // ------------------------------------------------------------------------
   always_ff @(posedge pclk4 or negedge n_p_reset4)
   begin
      if (!n_p_reset4)
      begin
         frm_d_addr_l <= '0;
         frm_d_addr_u <= '0;
         frm_s_addr_l <= '0;
         frm_s_addr_u <= '0;
         s_port       <= '0;
         mac_addr_l   <= '0;
         mac_addr_u   <= '0;
         best_bfr_age <= '1;     // nothing ages out by default
         div_clk      <= '0;
      end
      else if (write_en)
      begin
         case (paddr)
            al_frm_d_addr_l : frm_d_addr_l <= pwdata;
            al_frm_d_addr_u : frm_d_addr_u <= pwdata[15:0];
            al_frm_s_addr_l : frm_s_addr_l <= pwdata;
            al_frm_s_addr_u : frm_s_addr_u <= pwdata[15:0];
            al_s_port       : s_port       <= pwdata[port_w-1:0];
            al_mac_addr_l   : mac_addr_l   <= pwdata;
            al_mac_addr_u   : mac_addr_u   <= pwdata[15:0];
            al_bb_age       : best_bfr_age <= pwdata;
            al_div_clk      : div_clk      <= pwdata[7:0];
            default         : ;              // read only or command
         endcase
      end
   end

   // one-shot command, drops back to none after a single cycle
   always_ff @(posedge pclk4 or negedge n_p_reset4)
   begin
      if (!n_p_reset4)
         command <= cmd_none;
      else if (command != cmd_none)
         command <= cmd_none;
      else if (write_en && (paddr == al_command))
         command <= al_cmd_e'(pwdata[1:0]);
   end

   // ------------------------------------------------------------------------
   // last invalidated entry
   // ------------------------------------------------------------------------
   always_ff @(posedge pclk4 or negedge n_p_reset4)
   begin
      if (!n_p_reset4)
      begin
         lst_inv_addr_l <= '0;
         lst_inv_addr_u <= '0;
         lst_inv_port   <= '0;
      end
      else if (reused)           // overwrite by learning has priority
      begin
         lst_inv_addr_l <= lst_inv_addr_nrm[31:0];
         lst_inv_addr_u <= lst_inv_addr_nrm[47:32];
         lst_inv_port   <= lst_inv_port_nrm;
      end
      else if (inval_in_prog)    // aged out by scan
      begin
         lst_inv_addr_l <= lst_inv_addr_cmd[31:0];
         lst_inv_addr_u <= lst_inv_addr_cmd[47:32];
         lst_inv_port   <= lst_inv_port_cmd;
      end
   end

endmodule

`default_nettype wire

// ==== alut_pkg.sv ====
`default_nettype none

package alut_pkg;

   // widths shared by all lookup blocks
   localparam int mac_w   = 48;   // ethernet mac address
   localparam int port_w  = 2;    // source port number
   localparam int dmask_w = 5;    // four port bits plus broadcast
   localparam int time_w  = 32;   // current time and stamps

   // apb word addresses
   typedef enum logic [6:0] {
      al_frm_d_addr_l   = 7'h00,
      al_frm_d_addr_u   = 7'h04,
      al_frm_s_addr_l   = 7'h08,
      al_frm_s_addr_u   = 7'h0c,
      al_s_port         = 7'h10,
      al_d_port         = 7'h14,  // read only
      al_mac_addr_l     = 7'h18,
      al_mac_addr_u     = 7'h1c,
      al_cur_time       = 7'h20,  // read only
      al_bb_age         = 7'h24,
      al_div_clk        = 7'h28,
      al_status         = 7'h2c,  // read only
      al_command        = 7'h30,
      al_lst_inv_addr_l = 7'h34,  // read only
      al_lst_inv_addr_u = 7'h38,  // read only
      al_lst_inv_port   = 7'h3c   // read only
   } al_reg_e;

   typedef enum logic [1:0] {
      cmd_none  = 2'd0,
      cmd_check = 2'd1,   // lookup dest, learn source
      cmd_age   = 2'd2,   // scan and drop stale entries
      cmd_rsvd  = 2'd3    // no block reacts
   } al_cmd_e;

   typedef enum logic [1:0] {chk_idle, chk_lookup, chk_learn} chk_state_e;

   typedef enum logic {age_idle, age_scan} age_state_e;

endpackage

`default_nettype wire
